// ==== logic/taskDispatch_settings.svh ====
`ifndef TASK_DISPATCH_SETTINGS_SVH
`define TASK_DISPATCH_SETTINGS_SVH

// Core array
`define NUM_CORES 4
`define R0_WIDTH 8
`define INSN_WIDTH 32

// Frame layout
`define FRAME_LEN_WIDTH 6
`define FENCE_WIDTH 2

// Control word is fence + mask + R0 fields + length
`define CTRL_WORD_WIDTH \
	(`FENCE_WIDTH + `NUM_CORES + `NUM_CORES * `R0_WIDTH + `FRAME_LEN_WIDTH)

// Program store
`define TASK_MEM_DEPTH 64
`define TASK_ADDR_WIDTH 6

// Wide enough for either kind of word
`define TASK_WORD_WIDTH \
	((`CTRL_WORD_WIDTH > `INSN_WIDTH) ? `CTRL_WORD_WIDTH : `INSN_WIDTH)

`endif

// ==== logic/taskDispatchPkg.sv ====
`default_nettype none

`include "taskDispatch_settings.svh"

package taskDispatchPkg;

	typedef enum logic [`FENCE_WIDTH-1:0] {
		fenceNone    = 2'd0,
		fenceAcquire = 2'd1,	// Next frame waits for every core
		fenceRelease = 2'd2	// This frame waits for every core
	} fenceMode;

	typedef enum logic [2:0] {
		stIdle      = 3'd0,
		stFetch     = 3'd1,
		stControl   = 3'd2,
		stWaitReady = 3'd3,
		stIssue     = 3'd4,
		stHalt      = 3'd5
	} schedState;

	// Zero length with an empty mask marks program end
	typedef struct packed {
		logic [`FRAME_LEN_WIDTH-1:0] frameLen;
		logic [`NUM_CORES-1:0] coreMask;
		fenceMode fence;
		logic [`NUM_CORES*`R0_WIDTH-1:0] r0Values;	// Core 0 in the low bits
	} controlWord;

endpackage

`default_nettype wire

// ==== logic/taskMemIf.sv ====
`default_nettype none

`include "taskDispatch_settings.svh"

interface taskMemIf;

	logic wrEn;
	logic [`TASK_ADDR_WIDTH-1:0] wrAddr;
	logic [`TASK_WORD_WIDTH-1:0] wrData;

	logic [`TASK_ADDR_WIDTH-1:0] rdAddr;
	logic [`TASK_WORD_WIDTH-1:0] rdData;	// One cycle behind rdAddr

	modport writer (
		output wrEn,
		output wrAddr,
		output wrData
	);

	modport store (
		input wrEn,
		input wrAddr,
		input wrData
	);

	modport reader (
		output rdAddr,
		input rdData
	);

	modport fetch (
		input rdAddr,
		output rdData
	);

endinterface

`default_nettype wire

// ==== logic/taskLoader.sv ====
`default_nettype none

`include "taskDispatch_settings.svh"

module taskLoader (
	input logic clk,
	input logic reset,
	input logic loadValid,
	input logic [`TASK_WORD_WIDTH-1:0] loadWord,
	taskMemIf.writer mem,
	input logic programDone,
	output logic programReady
);

	taskDispatchPkg::controlWord loadCtrl;
	logic [`TASK_ADDR_WIDTH:0] wrCount;	// One extra bit to see a full store
	logic [`FRAME_LEN_WIDTH-1:0] frameLeft;
	logic accept;
	logic hasRoom;
	logic isEnd;

	assign loadCtrl = taskDispatchPkg::controlWord'(loadWord[`CTRL_WORD_WIDTH-1:0]);
	assign accept = loadValid && !programReady;
	assign hasRoom = wrCount < (`TASK_ADDR_WIDTH + 1)'(`TASK_MEM_DEPTH);
	assign isEnd = (loadCtrl.frameLen == '0) && (loadCtrl.coreMask == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			wrCount <= '0;
			frameLeft <= '0;
			programReady <= 1'b0;
			mem.wrEn <= 1'b0;
		end else begin
			mem.wrEn <= accept && hasRoom;
			if (programDone) begin
				programReady <= 1'b0;
				wrCount <= '0;
				frameLeft <= '0;
			end else if (accept) begin
				if (hasRoom)
					wrCount <= wrCount + 1'b1;
				// Only words between frames are control words
				if (frameLeft != '0)
					frameLeft <= frameLeft - 1'b1;
				else if (isEnd)
					programReady <= 1'b1;
				else
					frameLeft <= loadCtrl.frameLen;
			end
		end
	end

	always_ff @(posedge clk) begin
		mem.wrAddr <= wrCount[`TASK_ADDR_WIDTH-1:0];
		mem.wrData <= loadWord;
	end

endmodule

`default_nettype wire

// ==== logic/taskMemory.sv ====
`default_nettype none

`include "taskDispatch_settings.svh"

module taskMemory (
	input logic clk,
	taskMemIf.store memStore,
	taskMemIf.fetch memFetch
);

	logic [`TASK_WORD_WIDTH-1:0] words [`TASK_MEM_DEPTH];

	// Loader and scheduler are never active together
	always_ff @(posedge clk) begin
		if (memStore.wrEn)
			words[memStore.wrAddr] <= memStore.wrData;
	end

	always_ff @(posedge clk) begin
		memFetch.rdData <= words[memFetch.rdAddr];	// Registered read
	end

endmodule

`default_nettype wire

// ==== logic/taskScheduler.sv ====
`default_nettype none

`include "taskDispatch_settings.svh"

module taskScheduler (
	input logic clk,
	input logic reset,
	taskMemIf.reader mem,
	input logic programReady,
	output logic programDone,
	input logic [`NUM_CORES-1:0] ready,
	output logic [`NUM_CORES-1:0] start,
	output logic [`INSN_WIDTH-1:0] insnData,
	output logic [`NUM_CORES-1:0] initR0Valid,
	output logic [`NUM_CORES*`R0_WIDTH-1:0] initR0,
	output logic busy
);

	taskDispatchPkg::schedState state;
	taskDispatchPkg::fenceMode curFence;	// Fence of the frame being finished
	taskDispatchPkg::controlWord ctrl;

	logic [`TASK_ADDR_WIDTH-1:0] taskPtr;
	logic [`NUM_CORES-1:0] activeMask;
	logic [`FRAME_LEN_WIDTH-1:0] insnLeft;

	logic isEnd;
	logic fullFence;
	logic fenceOk;
	logic maskReady;

	assign mem.rdAddr = taskPtr;	// rdData stays valid while taskPtr holds

	assign ctrl = taskDispatchPkg::controlWord'(mem.rdData[`CTRL_WORD_WIDTH-1:0]);
	assign isEnd = (ctrl.frameLen == '0) && (ctrl.coreMask == '0);

	// Acquire behind us or release ahead means the whole array must drain
	assign fullFence = (curFence == taskDispatchPkg::fenceAcquire) ||
		(ctrl.fence == taskDispatchPkg::fenceRelease);
	assign fenceOk = fullFence ? (&ready) : ((ready & ctrl.coreMask) == ctrl.coreMask);

	assign maskReady = (ready & activeMask) == activeMask;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= taskDispatchPkg::stIdle;
			curFence <= taskDispatchPkg::fenceNone;
			taskPtr <= '0;
			activeMask <= '0;
			insnLeft <= '0;
			start <= '0;
			initR0Valid <= '0;
			programDone <= 1'b0;
			busy <= 1'b0;
		end else begin
			start <= '0;
			initR0Valid <= '0;
			programDone <= 1'b0;

			case (state)
				taskDispatchPkg::stIdle: begin
					taskPtr <= '0;
					insnLeft <= '0;
					curFence <= taskDispatchPkg::fenceNone;
					if (programReady) begin
						busy <= 1'b1;
						state <= taskDispatchPkg::stFetch;
					end
				end

				// Address is presented here, word arrives next cycle
				taskDispatchPkg::stFetch: begin
					state <= (insnLeft == '0) ? taskDispatchPkg::stControl :
						taskDispatchPkg::stWaitReady;
				end

				taskDispatchPkg::stControl: begin
					if (isEnd) begin
						programDone <= 1'b1;
						busy <= 1'b0;
						state <= taskDispatchPkg::stHalt;
					end else if (fenceOk) begin
						initR0Valid <= ctrl.coreMask;
						activeMask <= ctrl.coreMask;
						curFence <= ctrl.fence;
						insnLeft <= ctrl.frameLen;	// Zero means R0 only
						taskPtr <= taskPtr + 1'b1;
						state <= taskDispatchPkg::stFetch;
					end
				end

				taskDispatchPkg::stWaitReady: begin
					if (maskReady) begin
						start <= activeMask;
						state <= taskDispatchPkg::stIssue;
					end
				end

				// Start is high this cycle
				taskDispatchPkg::stIssue: begin
					taskPtr <= taskPtr + 1'b1;
					insnLeft <= insnLeft - 1'b1;
					state <= taskDispatchPkg::stFetch;
				end

				taskDispatchPkg::stHalt: begin
					if (!programReady)
						state <= taskDispatchPkg::stIdle;	// Loader has let go
				end

				default: begin
					state <= taskDispatchPkg::stIdle;
				end
			endcase
		end
	end

	// Payload only meaningful alongside its pulse
	always_ff @(posedge clk) begin
		if (state == taskDispatchPkg::stControl)
			initR0 <= ctrl.r0Values;
		if (state == taskDispatchPkg::stWaitReady)
			insnData <= mem.rdData[`INSN_WIDTH-1:0];
	end

endmodule

`default_nettype wire

// ==== logic/taskDispatchTop.sv ====
`default_nettype none

`include "taskDispatch_settings.svh"

module taskDispatchTop (
	input logic clk,
	input logic reset,
	input logic loadValid,
	input logic [`TASK_WORD_WIDTH-1:0] loadWord,
	input logic [`NUM_CORES-1:0] ready,
	output logic [`NUM_CORES-1:0] start,
	output logic [`INSN_WIDTH-1:0] insnData,
	output logic [`NUM_CORES-1:0] initR0Valid,
	output logic [`NUM_CORES*`R0_WIDTH-1:0] initR0,
	output logic busy
);

	logic programReady;
	logic programDone;

	taskMemIf memBus ();

	taskLoader loader_i (
		.clk(clk),
		.reset(reset),
		.loadValid(loadValid),
		.loadWord(loadWord),
		.mem(memBus),
		.programDone(programDone),
		.programReady(programReady)
	);

	// Same bus seen from both sides of the store
	taskMemory memory_i (
		.clk(clk),
		.memStore(memBus),
		.memFetch(memBus)
	);

	taskScheduler scheduler_i (
		.clk(clk),
		.reset(reset),
		.mem(memBus),
		.programReady(programReady),
		.programDone(programDone),
		.ready(ready),
		.start(start),
		.insnData(insnData),
		.initR0Valid(initR0Valid),
		.initR0(initR0),
		.busy(busy)
	);

endmodule

`default_nettype wire

// ==== tests/taskDispatch_assert.sv ====
`default_nettype none

`include "taskDispatch_settings.svh"

module taskDispatchAssert (
	input logic clk,
	input logic reset,
	input logic [`NUM_CORES-1:0] ready,
	input logic [`NUM_CORES-1:0] start,
	input logic [`NUM_CORES-1:0] initR0Valid,
	input logic programDone,
	input logic busy
);

	timeunit 1ns;
	timeprecision 100ps;

	// Cores lower ready once they see start, so look one edge back
	startOnlyReady: assert property (@(posedge clk) disable iff (reset)
		(start & ~$past(ready)) == '0)
		else $error("start issued to a core that was not ready");

	startNotWithInit: assert property (@(posedge clk) disable iff (reset)
		!((|start) && (|initR0Valid)))
		else $error("start and initR0Valid high together");

	idleOnDone: assert property (@(posedge clk) disable iff (reset)
		programDone |-> !busy)
		else $error("busy still high while programDone pulses");

endmodule

`default_nettype wire

// ==== tests/taskDispatchTb.sv ====
`default_nettype none

`include "taskDispatch_settings.svh"

module taskDispatchTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_PROGRAMS = 3;

	typedef logic [`TASK_WORD_WIDTH-1:0] taskWord;
	typedef logic [`NUM_CORES-1:0] coreBits;
	typedef logic [`NUM_CORES*`R0_WIDTH-1:0] r0Bits;
	typedef logic [`INSN_WIDTH-1:0] insnBits;
	typedef logic [`FRAME_LEN_WIDTH-1:0] lenBits;

	logic clk;
	logic reset;
	logic loadValid;
	taskWord loadWord;
	coreBits ready;
	coreBits start;
	insnBits insnData;
	coreBits initR0Valid;
	r0Bits initR0;
	logic busy;

	taskWord progWords[$];
	int progSize[$];
	int progEvents[$];

	// Expected pulses in program order
	bit expIsStart[$];
	coreBits expMask[$];
	r0Bits expR0[$];
	insnBits expInsn[$];
	bit expFull[$];	// Whole array must be idle first

	coreBits readySeen;	// Ready as the scheduler saw it
	coreBits readyPrev;
	int edgeCount;
	int lastPulseEdge;
	int minGap;	// Edges from a pulse until ready is looked at again
	bit busyWas;
	int holdLeft [`NUM_CORES];
	int eventsSeen;
	bit built;

	taskDispatchTop dut_i (
		.clk(clk),
		.reset(reset),
		.loadValid(loadValid),
		.loadWord(loadWord),
		.ready(ready),
		.start(start),
		.insnData(insnData),
		.initR0Valid(initR0Valid),
		.initR0(initR0),
		.busy(busy)
	);

	bind taskScheduler taskDispatchAssert assert_i (
		.clk(clk),
		.reset(reset),
		.ready(ready),
		.start(start),
		.initR0Valid(initR0Valid),
		.programDone(programDone),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abortRun(string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic reportError(string msg);
		abortRun($sformatf("ERROR at %0d ns: %s", $time, msg));
	endtask

	task automatic pushExpected(bit isStart, coreBits mask, r0Bits r0, insnBits insn, bit full);
		expIsStart.push_back(isStart);
		expMask.push_back(mask);
		expR0.push_back(r0);
		expInsn.push_back(insn);
		expFull.push_back(full);
	endtask

	task automatic buildProgram();
		taskDispatchPkg::controlWord cw;
		taskDispatchPkg::fenceMode lastFence;
		insnBits insn;
		int frames;
		int words;
		int events;
		frames = 2 + int'($urandom % 5);
		lastFence = taskDispatchPkg::fenceNone;
		words = 0;
		events = 0;
		for (int f = 0; f < frames; f++) begin
			cw.frameLen = lenBits'($urandom % 6);
			cw.coreMask = coreBits'(1 + $urandom % ((1 << `NUM_CORES) - 1));	// Never empty
			cw.fence = taskDispatchPkg::fenceMode'($urandom % 3);
			cw.r0Values = r0Bits'($urandom);
			progWords.push_back(taskWord'(cw));
			pushExpected(1'b0, cw.coreMask, cw.r0Values, '0,
				lastFence == taskDispatchPkg::fenceAcquire ||
				cw.fence == taskDispatchPkg::fenceRelease);
			lastFence = cw.fence;
			words += 1 + int'(cw.frameLen);
			events += 1 + int'(cw.frameLen);
			for (int i = 0; i < int'(cw.frameLen); i++) begin
				insn = insnBits'($urandom);
				progWords.push_back(taskWord'(insn));
				pushExpected(1'b1, cw.coreMask, '0, insn, 1'b0);
			end
		end
		progWords.push_back('0);	// End word
		progSize.push_back(words + 1);
		progEvents.push_back(events);
	endtask

	task automatic loadProgram(int first, int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			loadValid = 1'b1;
			loadWord = progWords[first + i];
		end
		@(negedge clk);
		loadValid = 1'b0;
	endtask

	// Junk loads while running must not disturb the program
	task automatic strobeWhileBusy();
		while (busy) begin
			loadValid = ($urandom % 3) == 0;
			loadWord = taskWord'({$urandom, $urandom});
			@(negedge clk);
		end
		loadValid = 1'b0;
	endtask

	task automatic checkPulse();
		coreBits needed;
		int gap;
		assert (start == '0 || initR0Valid == '0)
			else reportError("start and initR0Valid high in the same cycle");
		assert (expMask.size() > 0) else reportError("pulse with no expected event left");
		if (initR0Valid != '0) begin
			assert (!expIsStart[0] && initR0Valid == expMask[0])
				else reportError($sformatf("initR0Valid %b, expected %s %b", initR0Valid,
					expIsStart[0] ? "start" : "initR0Valid", expMask[0]));
			for (int c = 0; c < `NUM_CORES; c++) begin
				if (initR0Valid[c]) begin
					assert (initR0[c*`R0_WIDTH +: `R0_WIDTH] == expR0[0][c*`R0_WIDTH +: `R0_WIDTH])
						else reportError($sformatf("core %0d R0 value wrong", c));
				end
			end
			if (expFull[0]) begin
				assert (&readySeen) else reportError("fenced frame began with a core busy");
			end else begin
				assert ((readySeen & initR0Valid) == initR0Valid)
					else reportError("frame began on a busy core");
			end
		end else begin
			assert (expIsStart[0] && start == expMask[0])
				else reportError($sformatf("start %b, expected mask %b", start, expMask[0]));
			assert (insnData == expInsn[0])
				else reportError($sformatf("insnData %h, expected %h", insnData, expInsn[0]));
		end
		// Waiting past the first edge where its cores were ready is a stall
		needed = expFull[0] ? '1 : expMask[0];
		gap = edgeCount - lastPulseEdge;
		if (gap > minGap) begin
			assert ((readyPrev & needed) != needed)
				else reportError("pulse held back although its cores were ready");
		end
		lastPulseEdge = edgeCount;
		minGap = (start != '0) ? 3 : 2;
		void'(expIsStart.pop_front());
		void'(expMask.pop_front());
		void'(expR0.pop_front());
		void'(expInsn.pop_front());
		void'(expFull.pop_front());
		eventsSeen++;
	endtask

	always @(posedge clk) begin
		readySeen <= ready;
		readyPrev <= readySeen;
		edgeCount <= edgeCount + 1;
	end

	always @(negedge clk) begin
		if (!reset && busy && !busyWas) begin
			lastPulseEdge = edgeCount;	// Word 0 fetch begins
			minGap = 2;
		end
		busyWas = busy;
		if (!reset && (start != '0 || initR0Valid != '0))
			checkPulse();
	end

	// Core models, each busy for a random while after a start
	initial begin
		ready = '1;
		forever begin
			@(negedge clk);
			for (int c = 0; c < `NUM_CORES; c++) begin
				if (start[c]) begin
					assert (ready[c]) else reportError($sformatf("start reached busy core %0d", c));
					ready[c] = 1'b0;
					holdLeft[c] = 1 + int'($urandom % 6);
				end else if (holdLeft[c] > 0) begin
					holdLeft[c]--;
					if (holdLeft[c] == 0)
						ready[c] = 1'b1;
				end
			end
		end
	end

	initial begin
		int limit;
		wait (built);
		limit = 200;	// Margin for reset and gaps
		foreach (progSize[p])
			limit += progSize[p] * 20;
		#(limit * 8);
		abortRun("Watchdog timeout: the run did not finish in time");
	end

	initial begin
		int first;
		int expectedSeen;
		reset = 1'b1;
		loadValid = 1'b0;
		loadWord = '0;
		void'($urandom(32'h2bc1));
		for (int p = 0; p < NUM_PROGRAMS; p++)
			buildProgram();
		built = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		first = 0;
		expectedSeen = 0;
		for (int p = 0; p < NUM_PROGRAMS; p++) begin
			loadProgram(first, progSize[p]);
			while (!busy)
				@(negedge clk);
			strobeWhileBusy();
			first += progSize[p];
			expectedSeen += progEvents[p];
			assert (eventsSeen == expectedSeen)
				else reportError($sformatf("program %0d ended after %0d of %0d pulses",
					p, eventsSeen, expectedSeen));
			repeat (4) @(negedge clk);	// Let the loader and scheduler return to idle
		end
		if (expMask.size() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			abortRun("Expected pulses left unmatched at the end of the run");
		end
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+logic
logic/taskDispatchPkg.sv
logic/taskMemIf.sv
logic/taskLoader.sv
logic/taskMemory.sv
logic/taskScheduler.sv
logic/taskDispatchTop.sv
tests/taskDispatch_assert.sv
tests/taskDispatchTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the task dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f src.f --top-module taskDispatchTb -o simTb

./obj_dir/simTb 2>&1 | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
	echo "simulation ok"
else
	echo "simulation reported failure"
	exit 1
fi
